// ==== Bender.yml ====
package:
  name: cache_tag

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cache_pkg.sv
      - verilog/tag_store.sv
      - verilog/lru_ranker.sv
      - verilog/way_select.sv
      - verilog/cache_ctrl.sv
      - verilog/cache_tag_top.sv
  - target: simulation
    files:
      - bench/cache_chk.sv
      - bench/cache_tb.sv

// ==== bench/cache_chk.sv ====
module cache_chk (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   req_valid,
    input logic                   resp_valid,
    input cache_pkg::cache_resp_t resp
);

    int fail_cnt = 0;

    quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !resp_valid)
        else begin $error("resp_valid high while reset is held"); fail_cnt++; end

    way_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid |-> $onehot0(resp.way))
        else begin $error("resp.way has more than one bit set"); fail_cnt++; end

    stall_clean: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid && resp.stall |-> !resp.hit && !resp.evict_clr && !resp.evict_wb)
        else begin $error("stalled response carries a hit or evict strobe"); fail_cnt++; end

    wb_needs_clr: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid && resp.evict_wb |-> resp.evict_clr)
        else begin $error("write back strobe without evict clear"); fail_cnt++; end

    resp_follows: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid |=> resp_valid)
        else begin $error("lookup gave no response one cycle later"); fail_cnt++; end

    no_extra_resp: assert property (@(posedge clk) disable iff (!arst_n)
        !req_valid |=> !resp_valid)
        else begin $error("response without a lookup the cycle before"); fail_cnt++; end

endmodule

bind cache_tag_top cache_chk u_chk (
    .clk        (clk),
    .arst_n     (arst_n),
    .req_valid  (req_valid),
    .resp_valid (resp_valid),
    .resp       (resp)
);

// ==== bench/cache_tb.sv ====
`include "cache_macros.svh"

module cache_tb;

    logic                   clk;
    logic                   arst_n;
    logic                   req_valid;
    cache_pkg::cache_req_t  req;
    logic                   fill_done;
    cache_pkg::set_idx_t    fill_index;
    cache_pkg::way_vec_t    fill_way;
    logic                   resp_valid;
    cache_pkg::cache_resp_t resp;

    logic [7:0] m_tag   [`CACHE_SETS][`CACHE_WAYS];
    logic [3:0] m_valid [`CACHE_SETS];
    logic [3:0] m_dirty [`CACHE_SETS];
    logic [3:0] m_lock  [`CACHE_SETS];
    int         m_rank  [`CACHE_SETS][`CACHE_WAYS];  // way number per rank from least recent

    cache_pkg::cache_resp_t exp_q [$];
    cache_pkg::cache_resp_t exp_resp;
    logic [31:0]            rng_state = 32'he80f4eb8;
    int                     checks = 0;
    int                     errors = 0;
    int                     test_base = 0;

    cache_tag_top uut (
        .clk, .arst_n, .req_valid, .req, .fill_done, .fill_index, .fill_way,
        .resp_valid, .resp
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic cache_pkg::cache_req_t make_req(input logic [7:0] t, input logic [1:0] i,
                                                       input logic w);
        cache_pkg::cache_req_t rq;
        rq.tag   = t;
        rq.index = i;
        rq.write = w;
        return rq;
    endfunction

    // expected response for one lookup and the matching model update
    function automatic cache_pkg::cache_resp_t cache_ref(input cache_pkg::cache_req_t rq);
        cache_pkg::cache_resp_t r;
        int s;
        int v;
        int pos;
        r = '0;
        s = rq.index;
        v = -1;
        for (int w = 0; w < `CACHE_WAYS; w++)
            if (m_valid[s][w] && m_tag[s][w] == rq.tag) v = w;
        if (v >= 0) begin
            r.hit    = 1'b1;
            r.way[v] = 1'b1;
            if (rq.write) m_dirty[s][v] = 1'b1;
        end else if (m_lock[s] == 4'hf) begin
            r.stall = 1'b1;  // nothing changes
            return r;
        end else begin
            for (int w = `CACHE_WAYS - 1; w >= 0; w--)
                if (!m_valid[s][w] && !m_lock[s][w]) v = w;
            if (v < 0) begin
                for (int k = `CACHE_WAYS - 1; k >= 0; k--)
                    if (!m_lock[s][m_rank[s][k]]) v = m_rank[s][k];
            end
            r.way[v]    = 1'b1;
            r.evict_clr = m_valid[s][v];
            r.evict_wb  = m_valid[s][v] & m_dirty[s][v];
            r.evict_tag = m_valid[s][v] ? m_tag[s][v] : 8'h00;
            m_tag[s][v]   = rq.tag;
            m_valid[s][v] = 1'b1;
            m_lock[s][v]  = 1'b1;
            m_dirty[s][v] = rq.write;
        end
        pos = 0;
        for (int k = 0; k < `CACHE_WAYS; k++)
            if (m_rank[s][k] == v) pos = k;
        for (int k = pos; k < `CACHE_WAYS - 1; k++)
            m_rank[s][k] = m_rank[s][k+1];
        m_rank[s][`CACHE_WAYS-1] = v;
        return r;
    endfunction

    task automatic check_field(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    always @(negedge clk) begin
        if (arst_n && resp_valid) begin
            checks++;
            assert (exp_q.size() != 0) else begin
                $display("a response came out with no lookup outstanding");
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp_resp = exp_q.pop_front();
                check_field("resp.hit", exp_resp.hit, resp.hit);
                check_field("resp.stall", exp_resp.stall, resp.stall);
                check_field("resp.way", exp_resp.way, resp.way);
                check_field("resp.evict_wb", exp_resp.evict_wb, resp.evict_wb);
                check_field("resp.evict_clr", exp_resp.evict_clr, resp.evict_clr);
                check_field("resp.evict_tag", exp_resp.evict_tag, resp.evict_tag);
            end
        end
    end

    task automatic drive_cycle(input logic rv, input cache_pkg::cache_req_t rq, input logic fd,
                               input logic [1:0] fi, input logic [3:0] fw);
        @(posedge clk);
        #5;
        req_valid  = rv;
        req        = rq;
        fill_done  = fd;
        fill_index = fi;
        fill_way   = fw;
        if (rv) exp_q.push_back(cache_ref(rq));
        if (fd) m_lock[fi] = m_lock[fi] & ~fw;  // lookup at this edge still sees the lock
    endtask

    task automatic lookup(input logic [7:0] t, input logic [1:0] i, input logic w);
        drive_cycle(1'b1, make_req(t, i, w), 1'b0, 2'd0, 4'b0000);
    endtask

    task automatic fill(input logic [1:0] i, input logic [3:0] w);
        drive_cycle(1'b0, '0, 1'b1, i, w);
    endtask

    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        drive_cycle(1'b0, '0, 1'b0, 2'd0, 4'b0000);
        while (exp_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout in test %s, %0d responses never came", name, exp_q.size());
            errors++;
            exp_q.delete();
        end else begin
            $display("test %s finished with %0d errors", name, errors - test_base);
        end
        test_base = errors;
    endtask

    task automatic random_mix(input int count);
        logic [31:0] r;
        logic [3:0]  fw;
        int          start;
        for (int n = 0; n < count; n++) begin
            rng_state = xorshift(rng_state);
            r = rng_state;
            fw = '0;
            start = r[13:12];
            if (r[8]) begin
                for (int k = `CACHE_WAYS - 1; k >= 0; k--)
                    if (m_lock[r[11:10]][(start + k) % 4]) fw = 4'b0001 << ((start + k) % 4);
            end
            drive_cycle(r[0] | r[1], make_req(8'h40 + r[4:2], r[6:5], r[7]), |fw, r[11:10], fw);
        end
    endtask

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        fill_done  = 1'b0;
        fill_index = '0;
        fill_way   = '0;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            m_valid[s] = '0;
            m_dirty[s] = '0;
            m_lock[s]  = '0;
            for (int k = 0; k < `CACHE_WAYS; k++) m_rank[s][k] = k;
        end
        repeat (5) @(posedge clk);
        #5 arst_n = 1'b1;

        for (int i = 0; i < 4; i++) lookup(8'h10 + i, 2'd1, 1'b0);
        finish_test("cold_miss");

        lookup(8'h11, 2'd1, 1'b1);  // way 1 now dirty
        lookup(8'h13, 2'd1, 1'b0);
        finish_test("hit");

        for (int i = 0; i < 4; i++) fill(2'd1, 4'b0001 << i);
        lookup(8'h14, 2'd1, 1'b0);  // clean way 0 goes
        lookup(8'h15, 2'd1, 1'b0);  // clean way 2 goes
        lookup(8'h16, 2'd1, 1'b0);  // dirty way 1 goes with write back
        finish_test("replace");

        for (int i = 0; i < 4; i++) lookup(8'h20 + i, 2'd2, 1'b1);
        lookup(8'h24, 2'd2, 1'b0);
        lookup(8'h24, 2'd2, 1'b0);
        fill(2'd2, 4'b0100);
        lookup(8'h24, 2'd2, 1'b0);
        drive_cycle(1'b1, make_req(8'h25, 2'd2, 1'b0), 1'b1, 2'd2, 4'b0010);
        lookup(8'h25, 2'd2, 1'b0);
        finish_test("lock");

        random_mix(300);
        finish_test("random");

        errors = errors + uut.u_chk.fail_cnt;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/cache_pkg.sv
verilog/tag_store.sv
verilog/lru_ranker.sv
verilog/way_select.sv
verilog/cache_ctrl.sv
verilog/cache_tag_top.sv
bench/cache_chk.sv
bench/cache_tb.sv

// ==== verilog/cache_ctrl.sv ====
`include "cache_macros.svh"

module cache_ctrl (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    req_valid,
    input  cache_pkg::cache_req_t   req,
    input  logic                    fill_done,
    input  logic [`CACHE_IDX_W-1:0] fill_index,
    input  logic [`CACHE_WAYS-1:0]  fill_way,
    input  logic [`CACHE_WAYS-1:0]  hits,
    input  cache_pkg::alloc_t       alloc,
    output logic [`CACHE_IDX_W-1:0] lk_index,
    output logic [`CACHE_TAG_W-1:0] lk_tag,
    output logic                    upd_en,
    output logic [`CACHE_WAYS-1:0]  upd_way,
    output logic [`CACHE_TAG_W-1:0] upd_tag,
    output logic                    upd_dirty,
    output logic                    clr_en,
    output logic [`CACHE_IDX_W-1:0] clr_index,
    output logic [`CACHE_WAYS-1:0]  clr_way,
    output logic                    touch_en,
    output logic [`CACHE_IDX_W-1:0] touch_index,
    output logic [`CACHE_WAYS-1:0]  touch_way,
    output logic                    resp_valid,
    output cache_pkg::cache_resp_t  resp
);

    cache_pkg::cache_resp_t resp_d;
    logic                   commit;  // request that changes state

    // lookup runs straight off the request
    assign lk_index = req.index;
    assign lk_tag   = req.tag;

    assign commit = req_valid && !alloc.stall;

    // alloc already holds the hit way or the victim
    assign upd_en    = commit;
    assign upd_way   = alloc.way;
    assign upd_tag   = req.tag;
    assign upd_dirty = req.write;

    assign touch_en    = commit;
    assign touch_index = req.index;
    assign touch_way   = alloc.way;

    assign clr_en    = fill_done;
    assign clr_index = fill_index;
    assign clr_way   = fill_way;

    always_comb begin
        resp_d.hit       = |hits;
        resp_d.stall     = alloc.stall;
        resp_d.way       = alloc.way;
        resp_d.evict_wb  = alloc.evict_wb;
        resp_d.evict_clr = alloc.evict_clr;
        resp_d.evict_tag = alloc.evict_tag;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            resp <= resp_d;
        end
    end

endmodule

// ==== verilog/cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// geometry fixed by the one-hot way encoding and the rank state
`define CACHE_WAYS  4
`define CACHE_SETS  4
`define CACHE_IDX_W 2
`define CACHE_TAG_W 8

`endif

// ==== verilog/cache_pkg.sv ====
`include "cache_macros.svh"

package cache_pkg;

    localparam int WAY_ID_W = $clog2(`CACHE_WAYS);

    typedef logic [WAY_ID_W-1:0]     way_id_t;   // binary way number
    typedef logic [`CACHE_WAYS-1:0]  way_vec_t;  // one-hot way
    typedef logic [`CACHE_IDX_W-1:0] set_idx_t;
    typedef logic [`CACHE_TAG_W-1:0] tag_t;

    typedef tag_t [`CACHE_WAYS-1:0] set_tags_t;  // all stored tags of one set

    typedef struct packed {
        tag_t     tag;
        set_idx_t index;
        logic     write;
    } cache_req_t;

    typedef struct packed {
        way_vec_t valid;
        way_vec_t dirty;
        way_vec_t lock;   // set on allocation until fill done
    } way_flags_t;

    // way[0] is least recent, way[WAYS-1] most recent
    typedef struct packed {
        way_id_t [`CACHE_WAYS-1:0] way;
    } way_rank_t;

    typedef struct packed {
        way_vec_t way;
        logic     stall;
        logic     evict_wb;
        logic     evict_clr;
        tag_t     evict_tag;
    } alloc_t;

    typedef struct packed {
        logic     hit;
        logic     stall;
        way_vec_t way;
        logic     evict_wb;
        logic     evict_clr;
        tag_t     evict_tag;
    } cache_resp_t;

endpackage

// ==== verilog/cache_tag_top.sv ====
module cache_tag_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req_valid,
    input  cache_pkg::cache_req_t  req,
    input  logic                   fill_done,
    input  cache_pkg::set_idx_t    fill_index,
    input  cache_pkg::way_vec_t    fill_way,
    output logic                   resp_valid,
    output cache_pkg::cache_resp_t resp
);

    cache_pkg::set_idx_t   lk_index;
    cache_pkg::tag_t       lk_tag;
    cache_pkg::way_vec_t   hits;
    cache_pkg::way_flags_t flags;
    cache_pkg::set_tags_t  tags;
    cache_pkg::way_rank_t  rank;
    cache_pkg::alloc_t     alloc;

    logic                  upd_en;
    cache_pkg::way_vec_t   upd_way;
    cache_pkg::tag_t       upd_tag;
    logic                  upd_dirty;
    logic                  clr_en;
    cache_pkg::set_idx_t   clr_index;
    cache_pkg::way_vec_t   clr_way;
    logic                  touch_en;
    cache_pkg::set_idx_t   touch_index;
    cache_pkg::way_vec_t   touch_way;

    cache_ctrl u_ctrl (
        .clk, .arst_n, .req_valid, .req, .fill_done, .fill_index, .fill_way,
        .hits, .alloc, .lk_index, .lk_tag,
        .upd_en, .upd_way, .upd_tag, .upd_dirty,
        .clr_en, .clr_index, .clr_way,
        .touch_en, .touch_index, .touch_way,
        .resp_valid, .resp
    );

    tag_store u_tags (
        .clk, .arst_n, .lk_index, .lk_tag,
        .upd_en, .upd_way, .upd_tag, .upd_dirty,
        .clr_en, .clr_index, .clr_way,
        .hits, .flags, .tags
    );

    lru_ranker u_lru (
        .clk, .arst_n, .lk_index, .touch_en, .touch_index, .touch_way, .rank
    );

    way_select u_sel (
        .hits, .flags, .rank, .tags, .alloc
    );

endmodule

// ==== verilog/lru_ranker.sv ====
`include "cache_macros.svh"

module lru_ranker (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [`CACHE_IDX_W-1:0] lk_index,
    input  logic                    touch_en,
    input  logic [`CACHE_IDX_W-1:0] touch_index,
    input  logic [`CACHE_WAYS-1:0]  touch_way,
    output cache_pkg::way_rank_t    rank
);

    cache_pkg::way_rank_t ranks_q [`CACHE_SETS];
    cache_pkg::way_rank_t cur_rank;
    cache_pkg::way_rank_t nxt_rank;
    cache_pkg::way_id_t   touch_id;
    logic                 shifting;

    assign rank = ranks_q[lk_index];

    always_comb begin
        touch_id = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (touch_way[w]) begin
                touch_id = cache_pkg::way_id_t'(w);  // one-hot to number
            end
        end
    end

    // pull the touched way out, close the gap, put it on top
    always_comb begin
        cur_rank = ranks_q[touch_index];
        shifting = 1'b0;
        for (int r = 0; r < `CACHE_WAYS - 1; r++) begin
            if (cur_rank.way[r] == touch_id) begin
                shifting = 1'b1;
            end
            nxt_rank.way[r] = shifting ? cur_rank.way[r+1] : cur_rank.way[r];
        end
        nxt_rank.way[`CACHE_WAYS-1] = touch_id;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int r = 0; r < `CACHE_WAYS; r++) begin
                    ranks_q[s].way[r] <= cache_pkg::way_id_t'(r);  // way r at rank r
                end
            end
        end else if (touch_en) begin
            ranks_q[touch_index] <= nxt_rank;
        end
    end

endmodule

// ==== verilog/tag_store.sv ====
`include "cache_macros.svh"

module tag_store (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [`CACHE_IDX_W-1:0]      lk_index,
    input  logic [`CACHE_TAG_W-1:0]      lk_tag,
    input  logic                         upd_en,
    input  logic [`CACHE_WAYS-1:0]       upd_way,
    input  logic [`CACHE_TAG_W-1:0]      upd_tag,
    input  logic                         upd_dirty,
    input  logic                         clr_en,
    input  logic [`CACHE_IDX_W-1:0]      clr_index,
    input  logic [`CACHE_WAYS-1:0]       clr_way,
    output logic [`CACHE_WAYS-1:0]       hits,
    output cache_pkg::way_flags_t        flags,
    output cache_pkg::set_tags_t         tags
);

    logic [`CACHE_TAG_W-1:0] tag_mem [`CACHE_SETS][`CACHE_WAYS];

    logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] valid_q, valid_d;
    logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] dirty_q, dirty_d;
    logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] lock_q, lock_d;

    logic upd_hit;

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            tags[w] = tag_mem[lk_index][w];
            hits[w] = valid_q[lk_index][w] && (tag_mem[lk_index][w] == lk_tag);
        end
    end

    assign flags.valid = valid_q[lk_index];
    assign flags.dirty = dirty_q[lk_index];
    assign flags.lock  = lock_q[lk_index];

    assign upd_hit = |(hits & upd_way);

    always_comb begin
        valid_d = valid_q;
        dirty_d = dirty_q;
        lock_d  = lock_q;
        if (clr_en) begin
            lock_d[clr_index] = lock_d[clr_index] & ~clr_way;  // fill done
        end
        if (upd_en) begin
            if (upd_hit) begin
                dirty_d[lk_index] = dirty_q[lk_index] | (upd_way & {`CACHE_WAYS{upd_dirty}});
            end else begin
                valid_d[lk_index] = valid_q[lk_index] | upd_way;
                lock_d[lk_index]  = lock_d[lk_index] | upd_way;
                dirty_d[lk_index] = (dirty_q[lk_index] & ~upd_way) |
                                    (upd_way & {`CACHE_WAYS{upd_dirty}});
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lock_q  <= '0;
        end else begin
            valid_q <= valid_d;
            dirty_q <= dirty_d;
            lock_q  <= lock_d;
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (upd_en && !upd_hit && upd_way[w]) begin
                tag_mem[lk_index][w] <= upd_tag;  // new line
            end
        end
    end

endmodule

// ==== verilog/way_select.sv ====
`include "cache_macros.svh"

module way_select (
    input  logic [`CACHE_WAYS-1:0] hits,
    input  cache_pkg::way_flags_t  flags,
    input  cache_pkg::way_rank_t   rank,
    input  cache_pkg::set_tags_t   tags,
    output cache_pkg::alloc_t      alloc
);

    logic                    miss;
    logic                    all_locked;
    logic [`CACHE_WAYS-1:0]  free;        // invalid and unlocked
    logic [`CACHE_WAYS-1:0]  free_way;
    logic [`CACHE_WAYS-1:0]  lru_way;
    logic [`CACHE_WAYS-1:0]  victim;
    logic                    lru_found;
    logic                    victim_valid;
    logic                    victim_dirty;
    logic [`CACHE_TAG_W-1:0] victim_tag;

    assign miss       = ~|hits;
    assign all_locked = &flags.lock;
    assign free       = ~flags.valid & ~flags.lock;

    // lowest numbered free way
    always_comb begin
        free_way = '0;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (free[w]) begin
                free_way = '0;
                free_way[w] = 1'b1;
            end
        end
    end

    // walk ranks from least recent, skip locked ways
    always_comb begin
        lru_way   = '0;
        lru_found = 1'b0;
        for (int r = 0; r < `CACHE_WAYS; r++) begin
            if (!lru_found && !flags.lock[rank.way[r]]) begin
                lru_way[rank.way[r]] = 1'b1;
                lru_found = 1'b1;
            end
        end
    end

    assign victim       = (|free) ? free_way : lru_way;
    assign victim_valid = |(victim & flags.valid);
    assign victim_dirty = |(victim & flags.valid & flags.dirty);

    always_comb begin
        victim_tag = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (victim[w]) begin
                victim_tag = tags[w];
            end
        end
    end

    always_comb begin
        alloc = '0;
        if (!miss) begin
            alloc.way = hits;
        end else if (all_locked) begin
            alloc.stall = 1'b1;  // nothing to replace
        end else begin
            alloc.way       = victim;
            alloc.evict_clr = victim_valid;
            alloc.evict_wb  = victim_dirty;
            alloc.evict_tag = victim_valid ? victim_tag : '0;
        end
    end

endmodule
